/* execute.f */
+incdir+src
src/exec_pkg.sv
src/alu_core.sv
src/alu_unit.sv
src/booth_mul.sv
src/execute.sv
verif/execute_chk.sv
verif/execute_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f execute.f --top-module execute_tb -o Vexecute_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vexecute_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* verif/execute_tests.txt */
# lane(0 alu 1 mul) opcode funct3 funct7 imm pc rs1 rs2 pred_taken btb_pc_next flush
# then expected pv update_pc_next pc_next branch_taken, all hex
1 33 0 01 00000000 00003000 7fffffff 7fffffff 0 00000000 0 00000001 0 00000000 0
0 13 0 00 00000010 00001000 00000005 00000000 0 00000000 0 00000015 0 00000000 0
0 33 0 00 00000000 00001000 7fffffff 00000001 0 00000000 0 80000000 0 00000000 0
0 33 0 20 00000000 00001000 00000005 00000007 0 00000000 0 fffffffe 0 00000000 0
0 13 1 00 00000004 00001000 00000003 00000000 0 00000000 0 00000030 0 00000000 0
0 33 5 00 00000000 00001000 80000000 00000004 0 00000000 0 08000000 0 00000000 0
0 13 5 20 00000404 00001000 80000000 00000000 0 00000000 0 f8000000 0 00000000 0
0 33 5 20 00000000 00001000 f0000000 00000021 0 00000000 0 f8000000 0 00000000 0
0 13 4 00 ffffffff 00001000 0000ff00 00000000 0 00000000 0 ffff00ff 0 00000000 0
0 33 6 00 00000000 00001000 0f0f0000 000000f0 0 00000000 0 0f0f00f0 0 00000000 0
0 13 7 00 000000ff 00001000 12345678 00000000 0 00000000 0 00000078 0 00000000 0
1 33 1 01 00000000 00003004 80000000 80000000 0 00000000 0 40000000 0 00000000 0
0 33 2 00 00000000 00001000 ffffffff 00000001 0 00000000 0 00000001 0 00000000 0
0 33 3 00 00000000 00001000 ffffffff 00000001 0 00000000 0 00000000 0 00000000 0
0 13 2 00 fffffff0 00001000 fffffff8 00000000 0 00000000 0 00000000 0 00000000 0
0 13 3 00 00000010 00001000 00000008 00000000 0 00000000 0 00000001 0 00000000 0
0 37 0 00 12345000 00002000 00000000 00000000 0 00000000 0 12345000 0 00000000 0
0 17 0 00 00001000 00002000 00000000 00000000 0 00000000 0 00003000 0 00000000 0
0 6f 0 00 00000100 00001000 00000000 00000000 0 00000000 0 00001004 0 00001100 0
0 67 0 00 00000003 00001000 00002000 00000000 0 00000000 0 00001004 1 00002002 0
1 33 2 01 00000000 00003008 80000000 ffffffff 0 00000000 0 80000000 0 00000000 0
0 63 0 00 00000040 00001000 00000005 00000005 1 00001040 0 00000000 0 00000000 1
0 63 0 00 00000040 00001000 00000005 00000006 1 00001040 0 00000000 1 00001004 0
0 63 0 00 00000040 00001000 00000005 00000005 1 00001080 0 00000000 1 00001040 1
0 63 1 00 00000040 00001000 00000005 00000006 1 00001040 0 00000000 0 00000000 1
0 63 1 00 00000040 00001000 00000005 00000005 1 00001040 0 00000000 1 00001004 0
0 63 1 00 00000040 00001000 00000005 00000005 0 00001008 0 00000000 1 00001004 0
0 63 4 00 00000040 00001000 ffffffff 00000001 1 00001040 0 00000000 0 00000000 1
0 63 4 00 00000040 00001000 00000001 ffffffff 1 00001040 0 00000000 1 00001004 0
0 63 4 00 00000040 00001000 80000000 7fffffff 1 00001000 0 00000000 1 00001040 1
1 33 3 01 00000000 0000300c ffffffff ffffffff 0 00000000 0 fffffffe 0 00000000 0
0 63 5 00 00000040 00001000 00000001 ffffffff 1 00001040 0 00000000 0 00000000 1
0 63 5 00 00000040 00001000 ffffffff 00000001 1 00001040 0 00000000 1 00001004 0
0 63 5 00 00000040 00001000 00000003 00000003 1 00001004 0 00000000 1 00001040 1
0 63 6 00 00000040 00001000 00000001 ffffffff 1 00001040 0 00000000 0 00000000 1
0 63 6 00 00000040 00001000 ffffffff 00000001 1 00001040 0 00000000 1 00001004 0
0 63 6 00 00000040 00001000 ffffffff 00000001 0 00001040 0 00000000 1 00001004 0
0 63 7 00 00000040 00001000 ffffffff 00000001 1 00001040 0 00000000 0 00000000 1
0 63 7 00 00000040 00001000 ffffffff 00000001 0 00001004 0 00000000 1 00001040 1
0 63 7 00 00000040 00001000 00000000 00000001 0 00001010 0 00000000 1 00001004 0
1 33 0 01 00000000 00003010 12345678 00000000 0 00000000 0 00000000 0 00000000 0
1 33 1 01 00000000 00003014 ffffffff 00000002 0 00000000 0 ffffffff 0 00000000 0
0 13 0 00 00000010 00001000 00000005 00000000 0 00000000 1 00000000 0 00000000 0
1 33 0 01 00000000 00003018 00000003 00000004 0 00000000 1 00000000 0 00000000 0
1 33 0 01 00000000 0000301c fffffffd 00000005 0 00000000 0 fffffff1 0 00000000 0
0 33 0 00 00000000 00001000 00000002 00000003 0 00000000 0 00000005 0 00000000 0
0 13 6 00 00000001 00001000 00000010 00000000 0 00000000 0 00000011 0 00000000 0

/* verif/execute_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module execute_tb;

    localparam int MAX_TESTS = 64;
    localparam int NCOL = 15;
    // column order of the test file
    localparam int C_LANE = 0;
    localparam int C_OP = 1;
    localparam int C_F3 = 2;
    localparam int C_F7 = 3;
    localparam int C_IMM = 4;
    localparam int C_PC = 5;
    localparam int C_RS1 = 6;
    localparam int C_RS2 = 7;
    localparam int C_PT = 8;
    localparam int C_BTB = 9;
    localparam int C_FL = 10;
    localparam int C_PV = 11;
    localparam int C_UPD = 12;
    localparam int C_PCN = 13;
    localparam int C_TK = 14;

    logic clk;
    logic rst;
    logic flush;
    logic alu_issue;
    logic mul_issue;
    logic mul_ready;
    logic alu_wb_valid;
    logic mul_wb_valid;
    exec_pkg::issue_entry_t alu_entry;
    exec_pkg::issue_entry_t mul_entry;
    exec_pkg::exec_result_t alu_result;
    exec_pkg::exec_result_t mul_result;

    logic [31:0] tv [0:MAX_TESTS-1][0:NCOL-1];
    int n_tests;
    int tests_run;
    int tests_failed;
    int errors;
    int cycles;
    int cycle_limit;
    int seed = 32'h2209_031c;

    // multiplier job in flight
    logic mul_pending;
    logic mul_flushed;
    logic mul_busy_seen;
    int mul_idx;
    int mon_bad;
    exec_pkg::issue_entry_t mul_exp_entry;

    execute u_execute (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .alu_issue    (alu_issue),
        .alu_entry    (alu_entry),
        .mul_issue    (mul_issue),
        .mul_entry    (mul_entry),
        .mul_ready    (mul_ready),
        .alu_wb_valid (alu_wb_valid),
        .alu_result   (alu_result),
        .mul_wb_valid (mul_wb_valid),
        .mul_result   (mul_result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit in clock cycles
    initial begin
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp, inout int bad);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            bad++;
        end
    endtask

    task automatic check_result(input int i, input exec_pkg::exec_result_t r,
                                input exec_pkg::issue_entry_t e, inout int bad);
        check_val("pv", r.pv, tv[i][C_PV], bad);
        check_val("update_pc_next", 32'(r.update_pc_next), tv[i][C_UPD], bad);
        check_val("pc_next", r.pc_next, tv[i][C_PCN], bad);
        check_val("branch_taken", 32'(r.branch_taken), tv[i][C_TK], bad);
        check_val("regf_we", 32'(r.regf_we), 32'd1, bad);
        check_val("pd", 32'(r.pd), 32'(e.pd), bad);
        check_val("rd", 32'(r.rd), 32'(e.rd), bad);
        check_val("rob_entry", 32'(r.rob_entry), 32'(e.rob_entry), bad);
        check_val("pc", r.pc, e.pc, bad);
    endtask

    task automatic finish_test(input int i, input string lane, input int bad);
        tests_run++;
        if (bad != 0) begin
            tests_failed++;
            errors = errors + bad;
            $display("test %0d (%s) failed with %0d errors", i, lane, bad);
        end else begin
            $display("test %0d (%s) ok", i, lane);
        end
    endtask

    function automatic exec_pkg::issue_entry_t make_entry(input int i);
        exec_pkg::issue_entry_t e;
        logic [31:0] tag;
        e = '0;
        e.op_code = exec_pkg::opcode_e'(tv[i][C_OP][6:0]);
        e.funct3 = tv[i][C_F3][2:0];
        e.funct7 = tv[i][C_F7][6:0];
        e.imm = tv[i][C_IMM];
        e.pc = tv[i][C_PC];
        e.rs1_v = tv[i][C_RS1];
        e.rs2_v = tv[i][C_RS2];
        e.pred_taken = tv[i][C_PT][0];
        e.btb_pc_next = tv[i][C_BTB];
        tag = $random(seed);
        e.pd = tag[`EXEC_PREG_W-1:0];
        e.rd = tag[12:8];
        e.rob_entry = tag[16+`EXEC_ROB_W-1:16];
        return e;
    endfunction

    task automatic wait_mul_idle();
        while (mul_pending || !mul_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic run_alu(input int i);
        exec_pkg::issue_entry_t e;
        int bad;
        logic fl;
        bad = 0;
        fl = tv[i][C_FL][0];
        // a flush would also kill the multiplier job
        if (fl) begin
            wait_mul_idle();
        end
        e = make_entry(i);
        alu_entry = e;
        alu_issue = 1'b1;
        flush = fl;
        @(negedge clk);
        alu_issue = 1'b0;
        flush = 1'b0;
        if (fl) begin
            assert (!alu_wb_valid) else begin
                $display("alu wrote back although its issue was flushed (test %0d)", i);
                bad++;
            end
        end else begin
            assert (alu_wb_valid) else begin
                $display("alu result missing one cycle after issue (test %0d)", i);
                bad++;
            end
            check_result(i, alu_result, e, bad);
        end
        finish_test(i, "alu", bad);
    endtask

    task automatic run_mul(input int i);
        exec_pkg::issue_entry_t e;
        wait_mul_idle();
        e = make_entry(i);
        mul_entry = e;
        mul_issue = 1'b1;
        mul_exp_entry = e;
        mul_idx = i;
        mul_flushed = 1'b0;
        mul_pending = 1'b1;
        @(negedge clk);
        mul_issue = 1'b0;
        if (tv[i][C_FL][0]) begin
            repeat (3) @(negedge clk);
            flush = 1'b1;
            mul_flushed = 1'b1;
            @(negedge clk);
            flush = 1'b0;
        end
    endtask

    // watches multiplier completions while the alu stream runs
    always @(negedge clk) begin
        if (!rst) begin
            if (mul_wb_valid) begin
                mon_bad = 0;
                if (mul_pending) begin
                    assert (!mul_flushed) else begin
                        $display("multiplier wrote back a flushed job (test %0d)", mul_idx);
                        mon_bad++;
                    end
                    check_result(mul_idx, mul_result, mul_exp_entry, mon_bad);
                    finish_test(mul_idx, "mul", mon_bad);
                end else begin
                    $display("multiplier wrote back with no job issued at %0t", $time);
                    errors++;
                end
                mul_pending = 1'b0;
                mul_busy_seen = 1'b0;
            end else if (mul_pending && !mul_ready) begin
                mul_busy_seen = 1'b1;
            end else if (mul_pending && mul_ready && mul_busy_seen) begin
                mon_bad = 0;
                assert (mul_flushed) else begin
                    $display("multiplier went idle without a writeback (test %0d)", mul_idx);
                    mon_bad++;
                end
                finish_test(mul_idx, "mul flushed", mon_bad);
                mul_pending = 1'b0;
                mul_busy_seen = 1'b0;
            end
        end
    end

    task automatic load_tests();
        int fd;
        int got;
        string line;
        fd = $fopen("verif/execute_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file verif/execute_tests.txt");
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                got = $fgets(line, fd);
                if (got > 1 && line[0] != 8'h23) begin
                    got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        tv[n_tests][0], tv[n_tests][1], tv[n_tests][2], tv[n_tests][3],
                        tv[n_tests][4], tv[n_tests][5], tv[n_tests][6], tv[n_tests][7],
                        tv[n_tests][8], tv[n_tests][9], tv[n_tests][10], tv[n_tests][11],
                        tv[n_tests][12], tv[n_tests][13], tv[n_tests][14]);
                    if (got == NCOL) begin
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        alu_issue = 1'b0;
        mul_issue = 1'b0;
        alu_entry = '0;
        mul_entry = '0;
        mul_pending = 1'b0;
        mul_flushed = 1'b0;
        mul_busy_seen = 1'b0;
        mul_idx = 0;
        mul_exp_entry = '0;
        n_tests = 0;
        tests_run = 0;
        tests_failed = 0;
        errors = 0;
        cycles = 0;
        cycle_limit = 16 + MAX_TESTS * 40;
        load_tests();
        cycle_limit = 16 + n_tests * 40;

        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (int i = 0; i < n_tests; i++) begin
            if (tv[i][C_LANE] == 32'd1) begin
                run_mul(i);
            end else begin
                run_alu(i);
            end
        end
        wait_mul_idle();
        repeat (2) @(negedge clk);

        if (n_tests == 0 || tests_run != n_tests) begin
            $display("only %0d of %0d tests finished", tests_run, n_tests);
            errors++;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/execute_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_chk (
    input wire logic clk,
    input wire logic rst,
    input wire logic flush,
    input wire logic alu_issue,
    input wire logic alu_wb_valid,
    input wire logic mul_issue,
    input wire logic mul_ready,
    input wire logic mul_wb_valid
);

    // both lanes quiet right after reset
    assert property (@(posedge clk) rst |=> (!alu_wb_valid && !mul_wb_valid))
        else $error("writeback valid high in the cycle after reset");

    assert property (@(posedge clk) disable iff (rst) (alu_issue && !flush) |=> alu_wb_valid)
        else $error("alu issue not followed by alu writeback");

    assert property (@(posedge clk) disable iff (rst) mul_wb_valid |=> !mul_wb_valid)
        else $error("multiplier writeback longer than one cycle");

    assert property (@(posedge clk) disable iff (rst) !(mul_issue && !mul_ready))
        else $error("multiplier issue while not ready");

    // ready low from the issue edge until one edge after the writeback slot
    assert property (@(posedge clk) disable iff (rst)
        (mul_issue && mul_ready) |-> ##36 $rose(mul_ready))
        else $error("multiplier ready did not return 35 cycles after issue");

endmodule

bind execute execute_chk u_execute_chk (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .alu_issue    (alu_issue),
    .alu_wb_valid (alu_wb_valid),
    .mul_issue    (mul_issue),
    .mul_ready    (mul_ready),
    .mul_wb_valid (mul_wb_valid)
);

`default_nettype wire

/* src/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    // from the reservation station
    input  logic                   alu_issue,
    input  exec_pkg::issue_entry_t alu_entry,
    input  logic                   mul_issue,
    input  exec_pkg::issue_entry_t mul_entry,
    output logic                   mul_ready,
    // to writeback
    output logic                   alu_wb_valid,
    output exec_pkg::exec_result_t alu_result,
    output logic                   mul_wb_valid,
    output exec_pkg::exec_result_t mul_result
);

    alu_unit u_alu_unit (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .issue    (alu_issue),
        .entry    (alu_entry),
        .wb_valid (alu_wb_valid),
        .result   (alu_result)
    );

    booth_mul u_booth_mul (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .issue    (mul_issue),
        .entry    (mul_entry),
        .ready    (mul_ready),
        .wb_valid (mul_wb_valid),
        .result   (mul_result)
    );

endmodule

`default_nettype wire

/* src/booth_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module booth_mul (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   issue,
    input  exec_pkg::issue_entry_t entry,
    output logic                   ready,
    output logic                   wb_valid,
    output exec_pkg::exec_result_t result
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } mul_state_e;

    localparam int CNT_W = $clog2(`EXEC_MUL_STEPS + 1);

    mul_state_e               state;
    logic [CNT_W-1:0]         step_cnt;
    logic                     discard;
    logic                     stepping;

    exec_pkg::mul_op_e        in_op;
    logic                     a_signed;
    logic                     b_signed;
    logic [`EXEC_MUL_W-1:0]   mcand_ext;
    logic [`EXEC_MUL_W-1:0]   mplier_ext;

    logic [`EXEC_MUL_W-1:0]   mcand;
    logic [`EXEC_MUL_W:0]     acc;
    logic [`EXEC_MUL_W:0]     acc_sum;
    logic [`EXEC_MUL_W-1:0]   mq;
    logic                     q_prev;
    logic [`EXEC_PROD_W-1:0]  product;

    exec_pkg::mul_op_e        op_q;
    logic [`EXEC_PREG_W-1:0]  pd_q;
    logic [4:0]               rd_q;
    logic [`EXEC_ROB_W-1:0]   rob_q;
    logic [`EXEC_XLEN-1:0]    pc_q;

    // operand extension, mulhsu keeps rs1 signed and rs2 unsigned
    assign in_op      = exec_pkg::mul_op_e'(entry.funct3);
    assign a_signed   = (in_op != exec_pkg::mul_mulhu);
    assign b_signed   = (in_op == exec_pkg::mul_mul) || (in_op == exec_pkg::mul_mulh);
    assign mcand_ext  = {a_signed & entry.rs1_v[`EXEC_XLEN-1], entry.rs1_v};
    assign mplier_ext = {b_signed & entry.rs2_v[`EXEC_XLEN-1], entry.rs2_v};

    assign stepping = (state == st_busy) && (step_cnt != CNT_W'(`EXEC_MUL_STEPS));

    // booth recode on the multiplier lsb pair
    always_comb begin
        case ({mq[0], q_prev})
            2'b01:   acc_sum = acc + {mcand[`EXEC_MUL_W-1], mcand};
            2'b10:   acc_sum = acc - {mcand[`EXEC_MUL_W-1], mcand};
            default: acc_sum = acc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            step_cnt <= '0;
            discard  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (issue) begin
                        state    <= st_busy;
                        step_cnt <= '0;
                        discard  <= flush;
                    end
                end
                st_busy: begin
                    // job keeps running after a flush, only the writeback is dropped
                    if (flush) begin
                        discard <= 1'b1;
                    end
                    if (stepping) begin
                        step_cnt <= step_cnt + 1'b1;
                    end else begin
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && issue) begin
            mcand  <= mcand_ext;
            mq     <= mplier_ext;
            acc    <= '0;
            q_prev <= 1'b0;
            op_q   <= in_op;
            pd_q   <= entry.pd;
            rd_q   <= entry.rd;
            rob_q  <= entry.rob_entry;
            pc_q   <= entry.pc;
        end else if (stepping) begin
            // arithmetic shift of {acc, mq, q_prev}
            {acc, mq, q_prev} <= {acc_sum[`EXEC_MUL_W], acc_sum, mq};
        end
    end

    assign product  = {acc[`EXEC_MUL_W-1:0], mq};
    assign ready    = (state == st_idle);
    assign wb_valid = (state == st_done) && !discard;

    always_comb begin
        result           = '0;
        result.pd        = pd_q;
        result.rd        = rd_q;
        result.pc        = pc_q;
        result.rob_entry = rob_q;
        result.regf_we   = wb_valid;
        if (op_q == exec_pkg::mul_mul) begin
            result.pv = product[`EXEC_XLEN-1:0];
        end else begin
            result.pv = product[2*`EXEC_XLEN-1:`EXEC_XLEN];
        end
    end

endmodule

`default_nettype wire

/* src/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module alu_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   issue,
    input  exec_pkg::issue_entry_t entry,
    output logic                   wb_valid,
    output exec_pkg::exec_result_t result
);

    logic                   issue_q;
    exec_pkg::issue_entry_t entry_q;

    logic [`EXEC_XLEN-1:0]  op_a;
    logic [`EXEC_XLEN-1:0]  op_b;
    exec_pkg::alu_op_e      alu_op;
    exec_pkg::cmp_op_e      cmp_op;
    logic [`EXEC_XLEN-1:0]  alu_out;
    logic                   cmp_true;

    logic [`EXEC_XLEN-1:0]  pc_plus4;
    logic [`EXEC_XLEN-1:0]  pc_plus_imm;
    logic [`EXEC_XLEN-1:0]  br_next;
    logic                   br_redirect;

    // single issue register, a flush kills whatever was sampled
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            issue_q <= 1'b0;
            entry_q <= '0;
        end else begin
            issue_q <= issue;
            entry_q <= entry;
        end
    end

    alu_core u_alu_core (
        .a        (op_a),
        .b        (op_b),
        .alu_op   (alu_op),
        .cmp_op   (cmp_op),
        .alu_out  (alu_out),
        .cmp_true (cmp_true)
    );

    assign pc_plus4    = entry_q.pc + `EXEC_XLEN'(4);
    assign pc_plus_imm = entry_q.pc + entry_q.imm;

    // actual next pc of a branch and whether fetch guessed it wrong
    assign br_next     = cmp_true ? pc_plus_imm : pc_plus4;
    assign br_redirect = (cmp_true != entry_q.pred_taken) || (entry_q.btb_pc_next != br_next);

    assign wb_valid = issue_q;

    always_comb begin
        op_a   = entry_q.rs1_v;
        op_b   = entry_q.imm;
        alu_op = exec_pkg::alu_add;
        cmp_op = exec_pkg::cmp_blt;

        result                = '0;
        result.pd             = entry_q.pd;
        result.rd             = entry_q.rd;
        result.pc             = entry_q.pc;
        result.rob_entry      = entry_q.rob_entry;
        result.regf_we        = issue_q;

        case (entry_q.op_code)
            exec_pkg::op_lui: begin
                result.pv = entry_q.imm;
            end
            exec_pkg::op_auipc: begin
                result.pv = pc_plus_imm;
            end
            exec_pkg::op_imm, exec_pkg::op_reg: begin
                if (entry_q.op_code == exec_pkg::op_reg) begin
                    op_b = entry_q.rs2_v;
                end
                result.pv = alu_out;
                // funct3 010/011 are slt/sltu, 101 is the right shifts
                case (entry_q.funct3)
                    3'b010: begin
                        cmp_op    = exec_pkg::cmp_blt;
                        result.pv = {{(`EXEC_XLEN-1){1'b0}}, cmp_true};
                    end
                    3'b011: begin
                        cmp_op    = exec_pkg::cmp_bltu;
                        result.pv = {{(`EXEC_XLEN-1){1'b0}}, cmp_true};
                    end
                    3'b101: begin
                        alu_op = entry_q.funct7[5] ? exec_pkg::alu_sra : exec_pkg::alu_srl;
                    end
                    3'b000: begin
                        // sub exists only in register form
                        if (entry_q.op_code == exec_pkg::op_reg && entry_q.funct7[5]) begin
                            alu_op = exec_pkg::alu_sub;
                        end
                    end
                    default: begin
                        alu_op = exec_pkg::alu_op_e'(entry_q.funct3);
                    end
                endcase
            end
            exec_pkg::op_jal: begin
                // target already followed at fetch
                op_a           = entry_q.pc;
                result.pv      = pc_plus4;
                result.pc_next = alu_out;
            end
            exec_pkg::op_jalr: begin
                result.pv             = pc_plus4;
                result.pc_next        = {alu_out[`EXEC_XLEN-1:1], 1'b0};
                result.update_pc_next = 1'b1;
            end
            exec_pkg::op_br: begin
                op_b                  = entry_q.rs2_v;
                cmp_op                = exec_pkg::cmp_op_e'(entry_q.funct3);
                result.branch_taken   = cmp_true;
                result.update_pc_next = br_redirect;
                result.pc_next        = br_redirect ? br_next : '0;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module alu_core (
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    input  exec_pkg::alu_op_e     alu_op,
    input  exec_pkg::cmp_op_e     cmp_op,
    output logic [`EXEC_XLEN-1:0] alu_out,
    output logic                  cmp_true
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            exec_pkg::alu_add: alu_out = a + b;
            exec_pkg::alu_sll: alu_out = a << shamt;
            exec_pkg::alu_sra: alu_out = $unsigned($signed(a) >>> shamt);
            exec_pkg::alu_sub: alu_out = a - b;
            exec_pkg::alu_xor: alu_out = a ^ b;
            exec_pkg::alu_srl: alu_out = a >> shamt;
            exec_pkg::alu_or:  alu_out = a | b;
            default:           alu_out = a & b;
        endcase
    end

    // comparator runs in parallel, also feeds slt/sltu
    always_comb begin
        case (cmp_op)
            exec_pkg::cmp_beq:  cmp_true = (a == b);
            exec_pkg::cmp_bne:  cmp_true = (a != b);
            exec_pkg::cmp_blt:  cmp_true = ($signed(a) < $signed(b));
            exec_pkg::cmp_bge:  cmp_true = ($signed(a) >= $signed(b));
            exec_pkg::cmp_bltu: cmp_true = (a < b);
            default:            cmp_true = (a >= b);
        endcase
    end

endmodule

`default_nettype wire

/* src/exec_pkg.sv */
`default_nettype none

`include "exec_macros.svh"

package exec_pkg;

    // rv32 major opcodes handled by the alu lane
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011
    } opcode_e;

    // encodings line up with funct3 where the two overlap
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_e;

    // branch funct3 values
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic [2:0] {
        mul_mul    = 3'b000,
        mul_mulh   = 3'b001,
        mul_mulhsu = 3'b010,
        mul_mulhu  = 3'b011
    } mul_op_e;

    typedef struct packed {
        opcode_e                  op_code;
        logic [2:0]               funct3;
        logic [6:0]               funct7;
        logic [`EXEC_XLEN-1:0]    imm;
        logic [`EXEC_XLEN-1:0]    pc;
        logic [`EXEC_XLEN-1:0]    rs1_v;
        logic [`EXEC_XLEN-1:0]    rs2_v;
        logic [`EXEC_PREG_W-1:0]  pd;
        logic [4:0]               rd;
        logic [`EXEC_ROB_W-1:0]   rob_entry;
        // direction and target guessed at fetch
        logic                     pred_taken;
        logic [`EXEC_XLEN-1:0]    btb_pc_next;
    } issue_entry_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]    pv;
        logic [`EXEC_PREG_W-1:0]  pd;
        logic [4:0]               rd;
        logic [`EXEC_XLEN-1:0]    pc;
        logic [`EXEC_ROB_W-1:0]   rob_entry;
        logic                     regf_we;
        logic [`EXEC_XLEN-1:0]    pc_next;
        logic                     update_pc_next;
        logic                     branch_taken;
    } exec_result_t;

endpackage

`default_nettype wire

/* src/exec_macros.svh */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// datapath and address width
`define EXEC_XLEN 32

// multiplier operands carry one extra sign bit so mulhu/mulhsu fit a signed core
`define EXEC_MUL_W 33
`define EXEC_PROD_W 66

// one booth step per operand bit
`define EXEC_MUL_STEPS 33

// tag widths toward the register file and ROB
`define EXEC_PREG_W 6
`define EXEC_ROB_W 5

`endif
